//--- filelist.f
+incdir+bench
hw/mipsPkg.sv
hw/controlUnit.sv
hw/aluUnit.sv
hw/registerFile.sv
hw/dataMemory.sv
hw/fetchUnit.sv
hw/mipsCore.sv
bench/mipsCoreTb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator; exit status follows the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f filelist.f --top-module mipsCoreTb \
	&& ./obj_dir/VmipsCoreTb > sim.log 2>&1 \
	|| echo "STATUS: FAIL (build or simulation error)" >> sim.log
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0

//--- bench/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// architectural state, stepped once per accepted instruction
logic [31:0] modelRegs [32];
logic [31:0] modelMem [64];
logic [31:0] modelPc;

// trace fields expected for the most recent step
logic [31:0] expPc, expData, expStoreData;
logic [4:0]  expReg;
logic [5:0]  expStoreAddr;
logic        expWriteEn, expStore;

function automatic void stepModel(input logic [31:0] ins);
	logic [4:0]  rs, rt, rd;
	logic [31:0] a, b, sImm, zImm, pc4, nextPc, addr;
	rs = ins[25:21];
	rt = ins[20:16];
	rd = ins[15:11];
	a = modelRegs[rs];
	b = modelRegs[rt];
	sImm = {{16{ins[15]}}, ins[15:0]};
	zImm = {16'h0000, ins[15:0]};
	pc4 = modelPc + 32'd4;
	nextPc = pc4;
	addr = a + sImm;
	expPc = modelPc;
	expWriteEn = 1'b1; // immediates write rt
	expReg = rt;
	expData = '0;
	expStore = 1'b0;
	expStoreAddr = addr[7:2]; // byte address modulo 256
	expStoreData = b;
	case (ins[31:26])
		opRType: begin
			expReg = rd;
			case (ins[5:0])
				fnAdd: expData = a + b;
				fnSub: expData = a - b;
				fnAnd: expData = a & b;
				fnOr:  expData = a | b;
				fnXor: expData = a ^ b;
				fnNor: expData = ~(a | b);
				fnSlt: expData = {31'b0, ($signed(a) < $signed(b))};
				fnSll: expData = b << ins[10:6];
				fnSrl: expData = b >> ins[10:6];
				fnJr: begin
					expWriteEn = 1'b0;
					nextPc = a;
				end
				default: expWriteEn = 1'b0;
			endcase
		end
		opAddi: expData = a + sImm;
		opAndi: expData = a & zImm;
		opOri:  expData = a | zImm;
		opXori: expData = a ^ zImm;
		opSlti: expData = {31'b0, ($signed(a) < $signed(sImm))};
		opLw:   expData = modelMem[addr[7:2]];
		opSw: begin
			expWriteEn = 1'b0;
			expStore = 1'b1;
			modelMem[addr[7:2]] = b;
		end
		opBeq, opBne: begin
			expWriteEn = 1'b0;
			if ((a == b) == (ins[31:26] == opBeq)) nextPc = pc4 + (sImm << 2);
		end
		opJ: begin
			expWriteEn = 1'b0;
			nextPc = {pc4[31:28], ins[25:0], 2'b00};
		end
		opJal: begin
			expReg = 5'(linkReg);
			expData = pc4;
			nextPc = {pc4[31:28], ins[25:0], 2'b00};
		end
		default: expWriteEn = 1'b0;
	endcase
	if (expWriteEn && expReg != 5'd0) modelRegs[expReg] = expData; // r0 stays zero
	modelPc = nextPc;
endfunction

`endif

//--- bench/mipsCoreTb.sv
module mipsCoreTb;
	timeunit 1ns;
	timeprecision 1ps;
	import mipsPkg::*;

	localparam logic [31:0] seed = 32'hb8532e41;
	localparam int numInstr = 2000;
	localparam int cycleLimit = 4 * numInstr + 20;

	logic clk = 1'b0;
	logic reset, instrValid, instrReady;
	logic [31:0] instr, pc, retirePc, retireData, storeData;
	logic retireValid, retireWriteEn, storeEn;
	logic [4:0] retireReg;
	logic [5:0] storeAddr;
	int cycles = 0;
	int offered = 0;
	int retired = 0;
	logic accepting = 1'b0; // an accept happens at the coming rising edge

	funct_t rOps [10] = '{fnAdd, fnSub, fnAnd, fnOr, fnSlt, fnXor, fnNor, fnSll, fnSrl, fnJr};
	opcode_t otherOps [11] = '{opAddi, opAndi, opOri, opXori, opSlti, opLw, opSw, opBeq,
		opBne, opJ, opJal};

	`include "isaModel.svh"

	mipsCore uut (.clk, .reset, .instr, .instrValid, .instrReady, .pc, .retireValid,
		.retirePc, .retireWriteEn, .retireReg, .retireData, .storeEn, .storeAddr,
		.storeData);

	initial begin
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("timeout: %0d instructions retired after %0d cycles", retired, cycles);
			$display("STATUS: FAIL");
			$fatal(1, "run hit the cycle limit");
		end
	end

	task automatic compareValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1, "stopped at first error");
		end
	endtask

	function automatic logic [31:0] randomInstr(input int index);
		logic [4:0] rs, rt, rd, sh;
		logic [15:0] imm;
		int kind;
		opcode_t op;
		rs = 5'($urandom_range(0, 31));
		rt = 5'($urandom_range(0, 31));
		rd = 5'($urandom_range(0, 31));
		sh = 5'($urandom_range(0, 31));
		imm = 16'($urandom);
		kind = $urandom_range(0, 20);
		if (index < 64) return {opSw, 5'd0, rt, 16'(index * 4)}; // fill every word once
		if (kind < 10) begin
			if (rOps[kind] == fnJr) begin
				rs = 5'd0;
				// only jump through word-aligned registers
				for (int i = 1; i < 32; i++) begin
					if (modelRegs[i][1:0] == 2'b00 && $urandom_range(0, 3) == 0) rs = 5'(i);
				end
			end
			return {opRType, rs, rt, rd, sh, rOps[kind]};
		end
		op = otherOps[kind - 10];
		if (op == opBeq || op == opBne) imm = 16'($urandom_range(0, 15)) - 16'd8; // short hop
		return {op, rs, rt, imm};
	endfunction

	task automatic checkRetire();
		if (accepting) begin
			compareValue("retireValid", 32'd1, 32'(retireValid));
			compareValue("retirePc", expPc, retirePc);
			compareValue("retireWriteEn", 32'(expWriteEn), 32'(retireWriteEn));
			compareValue("storeEn", 32'(expStore), 32'(storeEn));
			if (expWriteEn) begin
				compareValue("retireReg", 32'(expReg), 32'(retireReg));
				compareValue("retireData", expData, retireData);
			end
			if (expStore) begin
				compareValue("storeAddr", 32'(expStoreAddr), 32'(storeAddr));
				compareValue("storeData", expStoreData, storeData);
			end
			retired++;
			instrValid = 1'b0;
		end else begin
			compareValue("idle retireValid", 32'd0, 32'(retireValid));
		end
	endtask

	initial begin
		void'($urandom(seed));
		reset = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		modelPc = '0;
		for (int i = 0; i < 32; i++) begin
			modelRegs[i] = '0;
		end
		repeat (4) @(posedge clk);
		@(negedge clk);
		compareValue("reset instrReady", 32'd0, 32'(instrReady));
		compareValue("reset retireValid", 32'd0, 32'(retireValid));
		compareValue("reset pc", 32'd0, pc);
		reset = 1'b0;
		while (retired < numInstr) begin
			@(negedge clk);
			checkRetire();
			compareValue("pc", modelPc, pc); // holds across idle cycles too
			if (!instrValid && offered < numInstr && $urandom_range(0, 3) != 0) begin
				instr = randomInstr(offered);
				instrValid = 1'b1;
				offered++;
			end
			accepting = instrValid && instrReady;
			if (accepting) stepModel(instr);
		end
		$display("STATUS: PASS");
		$finish;
	end

endmodule

//--- hw/mipsCore.sv
module mipsCore (
	input  logic                            clk,
	input  logic                            reset,
	input  logic [mipsPkg::dataWidth-1:0]    instr,
	input  logic                            instrValid,
	output logic                            instrReady,
	output logic [mipsPkg::dataWidth-1:0]    pc,
	output logic                            retireValid,
	output logic [mipsPkg::dataWidth-1:0]    retirePc,
	output logic                            retireWriteEn,
	output logic [mipsPkg::regAddrWidth-1:0] retireReg,
	output logic [mipsPkg::dataWidth-1:0]    retireData,
	output logic                            storeEn,
	output logic [mipsPkg::memAddrWidth-1:0] storeAddr,
	output logic [mipsPkg::dataWidth-1:0]    storeData
);
	import mipsPkg::*;

	logic [regAddrWidth-1:0] rs, rt, rd, destReg;
	logic [15:0] imm;
	logic [dataWidth-1:0] extImm, readData1, readData2, aluB, aluResult;
	logic [dataWidth-1:0] memReadData, loadData, pcPlus4, wbData;
	logic regDst, branch, memReadEn, memToReg, memWriteEn, regWriteEn;
	logic aluSrc, zeroExtend, isBne, jump, isJal, isJr;
	logic zero, branchTaken, accept;
	aluOp_t aluOp;

	assign rs  = instr[25:21];
	assign rt  = instr[20:16];
	assign rd  = instr[15:11];
	assign imm = instr[15:0];

	controlUnit ctrl (.opCode(opcode_t'(instr[31:26])), .funct(funct_t'(instr[5:0])),
		.regDst, .branch, .memReadEn, .memToReg, .memWriteEn, .regWriteEn, .aluSrc,
		.zeroExtend, .bne(isBne), .jump, .jal(isJal), .jr(isJr), .aluOp);

	assign extImm = zeroExtend ? {16'b0, imm} : {{16{imm[15]}}, imm}; // logical imm zero-ext
	assign aluB   = aluSrc ? extImm : readData2;

	registerFile regFile (.clk, .reset, .readReg1(rs), .readReg2(rt), .readData1,
		.readData2, .writeEn(accept && regWriteEn), .writeReg(destReg), .writeData(wbData));

	aluUnit alu (.aluOp, .a(readData1), .b(aluB), .shamt(instr[10:6]), .result(aluResult),
		.zero);

	// byte address wraps at 256, low two bits dropped
	dataMemory dataMem (.clk, .writeEn(accept && memWriteEn),
		.wordAddr(aluResult[memAddrWidth+1:2]), .writeData(readData2),
		.readData(memReadData));

	assign branchTaken = branch && (isBne ? !zero : zero);

	fetchUnit fetch (.clk, .reset, .instrValid, .instrReady, .pc, .branchTaken, .jump,
		.jr(isJr), .branchOffset({extImm[dataWidth-3:0], 2'b00}), .jumpTarget(instr[25:0]),
		.jrTarget(readData1), .accept);

	assign pcPlus4  = pc + dataWidth'(4); // link value
	assign loadData = memReadEn ? memReadData : '0;
	assign destReg  = isJal ? regAddrWidth'(linkReg) : (regDst ? rd : rt);
	assign wbData   = isJal ? pcPlus4 : (memToReg ? loadData : aluResult);

	always_ff @(posedge clk) begin
		if (reset) begin
			retireValid   <= 1'b0;
			retireWriteEn <= 1'b0;
			storeEn       <= 1'b0;
		end else begin
			retireValid   <= accept;
			retireWriteEn <= accept && regWriteEn;
			storeEn       <= accept && memWriteEn;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			retirePc   <= pc;
			retireReg  <= destReg;
			retireData <= wbData;
			storeAddr  <= aluResult[memAddrWidth+1:2];
			storeData  <= readData2;
		end
	end

	// an offered word must stay put until it is taken
	assert property (@(posedge clk) disable iff (reset)
		instrValid && !instrReady |=> instrValid && $stable(instr))
		else $error("instruction offer dropped or changed before acceptance");

endmodule

//--- hw/fetchUnit.sv
module fetchUnit (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         instrValid,
	output logic                         instrReady,
	output logic [mipsPkg::dataWidth-1:0] pc,
	input  logic                         branchTaken,
	input  logic                         jump,
	input  logic                         jr,
	input  logic [mipsPkg::dataWidth-1:0] branchOffset,
	input  logic [25:0]                  jumpTarget,
	input  logic [mipsPkg::dataWidth-1:0] jrTarget,
	output logic                         accept
);
	import mipsPkg::*;

	logic [dataWidth-1:0] pcPlus4;
	logic [dataWidth-1:0] nextPc;

	assign accept  = instrValid && instrReady;
	assign pcPlus4 = pc + dataWidth'(4);

	always_comb begin
		if (jr) // checked first since jr also raises jump
			nextPc = jrTarget;
		else if (jump)
			nextPc = {pcPlus4[dataWidth-1:dataWidth-4], jumpTarget, 2'b00};
		else if (branchTaken)
			nextPc = pcPlus4 + branchOffset;
		else
			nextPc = pcPlus4;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc         <= '0;
			instrReady <= 1'b0; // stays low one cycle past reset
		end else begin
			instrReady <= 1'b1;
			if (accept) pc <= nextPc; // pc holds while idle
		end
	end

	assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
		else $error("pc lost word alignment");

endmodule

//--- hw/dataMemory.sv
module dataMemory (
	input  logic                            clk,
	input  logic                            writeEn,
	input  logic [mipsPkg::memAddrWidth-1:0] wordAddr,
	input  logic [mipsPkg::dataWidth-1:0]    writeData,
	output logic [mipsPkg::dataWidth-1:0]    readData
);
	import mipsPkg::*;

	logic [dataWidth-1:0] mem [1 << memAddrWidth];

	always_ff @(posedge clk) begin
		if (writeEn) begin
			mem[wordAddr] <= writeData;
		end
	end

	// combinational read for single-cycle lw
	assign readData = mem[wordAddr];

endmodule

//--- hw/registerFile.sv
module registerFile (
	input  logic                            clk,
	input  logic                            reset,
	input  logic [mipsPkg::regAddrWidth-1:0] readReg1,
	input  logic [mipsPkg::regAddrWidth-1:0] readReg2,
	output logic [mipsPkg::dataWidth-1:0]    readData1,
	output logic [mipsPkg::dataWidth-1:0]    readData2,
	input  logic                            writeEn,
	input  logic [mipsPkg::regAddrWidth-1:0] writeReg,
	input  logic [mipsPkg::dataWidth-1:0]    writeData
);
	import mipsPkg::*;

	localparam int numRegs = 1 << regAddrWidth;

	logic [dataWidth-1:0] regs [numRegs];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && writeReg != '0) begin // $zero never written
			regs[writeReg] <= writeData;
		end
	end

	assign readData1 = (readReg1 == '0) ? '0 : regs[readReg1];
	assign readData2 = (readReg2 == '0) ? '0 : regs[readReg2];

endmodule

//--- hw/aluUnit.sv
module aluUnit (
	input  mipsPkg::aluOp_t              aluOp,
	input  logic [mipsPkg::dataWidth-1:0] a,
	input  logic [mipsPkg::dataWidth-1:0] b,
	input  logic [4:0]                   shamt,
	output logic [mipsPkg::dataWidth-1:0] result,
	output logic                         zero
);
	import mipsPkg::*;

	logic lessThan;

	assign lessThan = $signed(a) < $signed(b);

	always_comb begin
		case (aluOp)
			aluAdd:  result = a + b;
			aluSub:  result = a - b; // also the branch compare
			aluAnd:  result = a & b;
			aluOr:   result = a | b;
			aluSlt:  result = {{(dataWidth-1){1'b0}}, lessThan};
			aluXor:  result = a ^ b;
			aluNor:  result = ~(a | b);
			aluSll:  result = b << shamt; // shifts act on rt
			aluSrl:  result = b >> shamt;
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

//--- hw/controlUnit.sv
module controlUnit (
	input  mipsPkg::opcode_t opCode,
	input  mipsPkg::funct_t  funct,
	output logic             regDst,
	output logic             branch,
	output logic             memReadEn,
	output logic             memToReg,
	output logic             memWriteEn,
	output logic             regWriteEn,
	output logic             aluSrc,
	output logic             zeroExtend,
	output logic             bne,
	output logic             jump,
	output logic             jal,
	output logic             jr,
	output mipsPkg::aluOp_t  aluOp
);
	import mipsPkg::*;

	always_comb begin
		// everything inactive unless the decode says otherwise
		regDst     = 1'b0;
		branch     = 1'b0;
		memReadEn  = 1'b0;
		memToReg   = 1'b0;
		memWriteEn = 1'b0;
		regWriteEn = 1'b0;
		aluSrc     = 1'b0;
		zeroExtend = 1'b0;
		bne        = 1'b0;
		jump       = 1'b0;
		jal        = 1'b0;
		jr         = 1'b0;
		aluOp      = aluAdd;

		case (opCode)
			opRType: begin
				regDst     = 1'b1;
				regWriteEn = 1'b1;
				case (funct)
					fnAdd: aluOp = aluAdd;
					fnSub: aluOp = aluSub;
					fnAnd: aluOp = aluAnd;
					fnOr:  aluOp = aluOr;
					fnSlt: aluOp = aluSlt;
					fnXor: aluOp = aluXor;
					fnNor: aluOp = aluNor;
					fnSll: aluOp = aluSll;
					fnSrl: aluOp = aluSrl;
					fnJr: begin
						regDst     = 1'b0;
						regWriteEn = 1'b0;
						jump       = 1'b1;
						jr         = 1'b1;
					end
					default: begin // unknown funct is a no-op
						regDst     = 1'b0;
						regWriteEn = 1'b0;
					end
				endcase
			end
			opAddi: begin
				regWriteEn = 1'b1;
				aluSrc     = 1'b1;
			end
			opAndi: begin
				regWriteEn = 1'b1;
				aluSrc     = 1'b1;
				zeroExtend = 1'b1;
				aluOp      = aluAnd;
			end
			opOri: begin
				regWriteEn = 1'b1;
				aluSrc     = 1'b1;
				zeroExtend = 1'b1;
				aluOp      = aluOr;
			end
			opXori: begin
				regWriteEn = 1'b1;
				aluSrc     = 1'b1;
				zeroExtend = 1'b1;
				aluOp      = aluXor;
			end
			opSlti: begin
				regWriteEn = 1'b1;
				aluSrc     = 1'b1;
				aluOp      = aluSlt; // signed compare
			end
			opLw: begin
				memReadEn  = 1'b1;
				memToReg   = 1'b1;
				regWriteEn = 1'b1;
				aluSrc     = 1'b1;
			end
			opSw: begin
				memWriteEn = 1'b1;
				aluSrc     = 1'b1;
			end
			opBeq: begin
				branch = 1'b1;
				aluOp  = aluSub;
			end
			opBne: begin
				branch = 1'b1;
				bne    = 1'b1;
				aluOp  = aluSub;
			end
			opJ: jump = 1'b1;
			opJal: begin
				jump       = 1'b1;
				jal        = 1'b1;
				regWriteEn = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

//--- hw/mipsPkg.sv
package mipsPkg;

	localparam int dataWidth    = 32;
	localparam int regAddrWidth = 5;
	localparam int memAddrWidth = 6; // 64 data words
	localparam int linkReg      = 31;

	// primary opcode field, instr[31:26]
	typedef enum logic [5:0] {
		opRType = 6'h00,
		opJ     = 6'h02,
		opJal   = 6'h03,
		opBeq   = 6'h04,
		opBne   = 6'h05,
		opAddi  = 6'h08,
		opSlti  = 6'h0a,
		opAndi  = 6'h0c,
		opOri   = 6'h0d,
		opXori  = 6'h0e,
		opLw    = 6'h23,
		opSw    = 6'h2b
	} opcode_t;

	// funct field of R-type, instr[5:0]
	typedef enum logic [5:0] {
		fnSll = 6'h00,
		fnSrl = 6'h02,
		fnJr  = 6'h08,
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr  = 6'h25,
		fnXor = 6'h26,
		fnNor = 6'h27,
		fnSlt = 6'h2a
	} funct_t;

	// ALU select codes
	typedef enum logic [3:0] {
		aluAdd = 4'b0000,
		aluSub = 4'b0001,
		aluAnd = 4'b0010,
		aluOr  = 4'b0011,
		aluSlt = 4'b0100,
		aluXor = 4'b0101,
		aluNor = 4'b0110,
		aluSll = 4'b0111,
		aluSrl = 4'b1000
	} aluOp_t;

endpackage
